// File: commit_beat_if.sv
// Group accumulator to commit link
`default_nettype none

interface commit_beat_if
   import vpu_commit_pkg::*;
();

   vgroup_t group_nxt;
   vmask_t  mask_nxt;
   fflags_t fflags_nxt;
   logic    commit_fire;

   modport accum (
      output group_nxt,
      output mask_nxt,
      output fflags_nxt,
      input  commit_fire
   );

   modport merge (
      input  group_nxt,
      input  mask_nxt,
      input  fflags_nxt,
      output commit_fire
   );

endinterface

`default_nettype wire

// File: commit_merge.sv
// Commit port merge and register
`default_nettype none

module commit_merge
   import vpu_commit_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_rf_wr,
   input  xreg_t             i_rf_wrdata,
   input  logic              i_fp_rf_wr,
   input  xreg_t             i_fp_rf_wrdata,
   input  logic              i_vec_commit,
   input  logic              i_head_last,
   commit_beat_if.merge      beat,
   output logic              o_commit_valid,
   output vgroup_t           o_commit_data,
   output vmask_t            o_commit_mask,
   output fflags_t           o_commit_fflags
);

   logic    commit_fire;
   vgroup_t vec_data;
   xreg_t   scalar_data;
   vgroup_t commit_data;
   fflags_t commit_fflags;

   // Vector commit waits for the last beat of the head entry
   assign commit_fire = i_rf_wr || i_fp_rf_wr || (i_vec_commit && i_head_last);
   assign beat.commit_fire = commit_fire;

   assign vec_data    = i_vec_commit ? beat.group_nxt : '0;
   assign scalar_data = ({XLEN{i_rf_wr}}    & i_rf_wrdata) |
                        ({XLEN{i_fp_rf_wr}} & i_fp_rf_wrdata);

   always_comb begin
      commit_data             = vec_data;
      commit_data[XLEN-1:0]   = vec_data[XLEN-1:0] | scalar_data;
      commit_fflags           = i_vec_commit ? beat.fflags_nxt : '0;
   end

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         o_commit_valid <= 1'b0;
      end else begin
         o_commit_valid <= commit_fire;
      end
   end

   // Payload held until the next commit
   always_ff @(posedge i_clk) begin
      if (commit_fire) begin
         o_commit_data   <= commit_data;
         o_commit_mask   <= beat.mask_nxt;
         o_commit_fflags <= commit_fflags;
      end
   end

endmodule

`default_nettype wire

// File: lq_last_tracker.sv
// Load queue last-beat tracker
`default_nettype none

module lq_last_tracker
   import vpu_commit_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_reset,
   input  logic      i_lq_alloc,
   input  lqid_t     i_lq_alloc_id,
   input  logic      i_lq_done,
   input  logic      i_lq_commit,
   output lq_flags_t o_lq_last,
   output logic      o_head_last
);

   lq_flags_t lq_last;
   lqid_t     alloc_id_q;
   lqid_t     head_ptr;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lq_last    <= '0;
         alloc_id_q <= '0;
      end else begin
         if (i_lq_alloc) begin
            // Single-beat instructions are last at allocation
            lq_last[i_lq_alloc_id] <= i_lq_done;
            alloc_id_q             <= i_lq_alloc_id;
         end else if (i_lq_done) begin
            lq_last[alloc_id_q] <= 1'b1;
         end
      end
   end

   // Retire pointer
   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         head_ptr <= '0;
      end else if (i_lq_commit) begin
         if (head_ptr == LQID_W'(LQ_DEPTH - 1)) begin
            head_ptr <= '0;
         end else begin
            head_ptr <= head_ptr + 1'b1;
         end
      end
   end

   assign o_lq_last   = lq_last;
   assign o_head_last = lq_last[head_ptr];

endmodule

`default_nettype wire

// File: mem_req_gate.sv
// Memory request gate for empty loads
`default_nettype none

module mem_req_gate
   import vpu_commit_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_reset,
   input  logic      i_req_prequal,
   input  logic      i_req_load,
   input  byten_t    i_req_byten,
   input  req_id_t   i_req_id,
   input  logic      i_req_last_raw,
   input  logic      i_data_req_rtr,
   input  lq_flags_t i_lq_last,
   output logic      o_data_req,
   output logic      o_mem_last,
   output logic      o_rd_data_vld_2,
   output req_id_t   o_rd_data_resp_id_2
);

   logic  empty_load;
   lqid_t req_lqid;

   assign empty_load = i_req_load && ~|i_req_byten;
   assign req_lqid   = i_req_id[LQID_W-1:0];

   // Empty loads never reach the memory
   assign o_data_req = i_req_prequal && !empty_load;
   assign o_mem_last = i_req_last_raw && i_lq_last[req_lqid];

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         o_rd_data_vld_2 <= 1'b0;
      end else begin
         o_rd_data_vld_2 <= i_req_prequal && i_data_req_rtr && empty_load;
      end
   end

   // Synthetic response id
   always_ff @(posedge i_clk) begin
      o_rd_data_resp_id_2 <= i_req_id;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
vpu_commit_pkg.sv
commit_beat_if.sv
lq_last_tracker.sv
vrf_group_accum.sv
commit_merge.sv
mem_req_gate.sv
vpu_commit_top.sv
tb_vpu_commit.sv

// File: tb_vpu_commit_model.svh
// Commit and gate reference model
lq_flags_t mdl_last  = '0;
lqid_t     mdl_alloc = '0;
lqid_t     mdl_head  = '0;
vgroup_t   mdl_group = '0;
vmask_t    mdl_mask  = '0;
fflags_t   mdl_flags = '0;
int        mdl_slot  = 0;

// Expected results for this cycle's inputs, then the state after the next edge
function automatic void predict(output logic fire, output vgroup_t data,
                                output vmask_t mask, output fflags_t flags,
                                output logic [2:0] gate);
   logic empty;
   empty = i_req_load && (i_req_byten == '0);
   // Data request, memory last, synthetic response
   gate  = {i_req_prequal && !empty, i_req_last_raw && mdl_last[i_req_id[LQID_W-1:0]],
            i_req_prequal && i_data_req_rtr && empty};
   fire  = i_rf_wr || i_fp_rf_wr || (i_vec_commit && mdl_last[mdl_head]);
   if (i_vrf_wr) begin
      mdl_group[VLEN*mdl_slot +: VLEN] = i_vrf_wrdata;
      mdl_mask[mdl_slot]               = (i_csr_vl != 0);
      mdl_flags                        = mdl_flags | i_vrf_wrexc;
      mdl_slot                         = (mdl_slot + 1) % LMUL_MAX;
   end
   data           = i_vec_commit ? mdl_group : '0;
   data[XLEN-1:0] = data[XLEN-1:0] | (i_rf_wr ? i_rf_wrdata : '0) |
                    (i_fp_rf_wr ? i_fp_rf_wrdata : '0);
   mask           = mdl_mask;
   flags          = i_vec_commit ? mdl_flags : '0;
   if (fire) begin
      mdl_group = '0;
      mdl_mask  = '0;
      mdl_flags = '0;
      mdl_slot  = 0;
   end
   if (i_lq_alloc) begin
      mdl_last[i_lq_alloc_id] = i_lq_done;
      mdl_alloc               = i_lq_alloc_id;
   end else if (i_lq_done) begin
      mdl_last[mdl_alloc] = 1'b1;
   end
   if (i_lq_commit) begin
      mdl_head = (mdl_head == LQ_DEPTH - 1) ? '0 : mdl_head + 1'b1;
   end
endfunction

// File: tb_vpu_commit.sv
// Vector commit testbench
`default_nettype none

module tb_vpu_commit
   import vpu_commit_pkg::*;
();

   localparam int CLK_PERIOD  = 40;
   localparam int NUM_GROUPS  = 10;
   // Worst group is alloc, eight beats and four strobe cycles
   localparam int STIM_CYCLES = 14 + NUM_GROUPS * 13;

   logic    i_clk, i_reset, i_lq_alloc, i_lq_done, i_lq_commit, i_vec_commit;
   logic    i_rf_wr, i_fp_rf_wr, i_vrf_wr, i_req_prequal, i_req_load;
   logic    i_req_last_raw, i_data_req_rtr;
   logic    o_commit_valid, o_data_req, o_mem_last, o_rd_data_vld_2;
   vl_t     i_csr_vl;
   lqid_t   i_lq_alloc_id;
   xreg_t   i_rf_wrdata, i_fp_rf_wrdata;
   vreg_t   i_vrf_wrdata;
   fflags_t i_vrf_wrexc, o_commit_fflags;
   byten_t  i_req_byten;
   req_id_t i_req_id, o_rd_data_resp_id_2;
   vgroup_t o_commit_data;
   vmask_t  o_commit_mask;
   int      errors = 0;

   `include "tb_vpu_commit_model.svh"

   vpu_commit_top DUT (.*);

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   initial begin
      #((STIM_CYCLES + 20) * CLK_PERIOD);
      $display("Timeout: stimulus did not complete in time");
      $display("TESTBENCH FAILED");
      $fatal(1, "Watchdog expired");
   end

   task automatic check_value(input string what, input logic [1023:0] got,
                              input logic [1023:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // Strobes low, request side random
   task automatic next_cycle();
      @(posedge i_clk);
      #2;
      {i_lq_alloc, i_lq_done, i_lq_commit, i_vec_commit, i_rf_wr, i_fp_rf_wr, i_vrf_wr} = '0;
      {i_req_prequal, i_req_load, i_req_last_raw, i_data_req_rtr} = 4'($urandom);
      i_req_byten = ($urandom % 3 == 0) ? '0 : byten_t'($urandom);
      i_req_id    = req_id_t'($urandom);
   endtask

   task automatic send_beats(input int n);
      repeat (n) begin
         i_vrf_wr     = 1'b1;
         i_vrf_wrdata = {$urandom, $urandom};
         i_vrf_wrexc  = fflags_t'($urandom);
         i_csr_vl     = ($urandom % 4 == 0) ? '0 : vl_t'($urandom);
         next_cycle();
      end
   endtask

   initial begin
      int n;
      void'($urandom(32'h9408));
      i_reset = 1'b1;
      {i_lq_alloc, i_lq_done, i_lq_commit, i_vec_commit, i_rf_wr, i_fp_rf_wr, i_vrf_wr} = '0;
      {i_req_prequal, i_req_load, i_req_last_raw, i_data_req_rtr, i_req_byten, i_req_id} = '0;
      {i_lq_alloc_id, i_csr_vl, i_rf_wrdata, i_fp_rf_wrdata, i_vrf_wrdata, i_vrf_wrexc} = '0;
      repeat (5) next_cycle();
      i_reset = 1'b0;
      // Scalar and FP writebacks, each with a vector beat that the commit drops
      repeat (6) begin
         i_rf_wr        = 1'($urandom);
         i_fp_rf_wr     = !i_rf_wr || ($urandom % 4 == 0);
         i_rf_wrdata    = {$urandom, $urandom};
         i_fp_rf_wrdata = {$urandom, $urandom};
         i_vrf_wr       = 1'b1;
         i_vrf_wrdata   = {$urandom, $urandom};
         i_vrf_wrexc    = fflags_t'($urandom);
         i_csr_vl       = vl_t'($urandom);
         next_cycle();
      end
      for (int g = 0; g < NUM_GROUPS; g++) begin
         // Every third entry is last at allocation
         i_lq_alloc    = 1'b1;
         i_lq_alloc_id = lqid_t'(g);
         i_lq_done     = (g % 3 == 0);
         next_cycle();
         n = 1 + $urandom % 4;
         send_beats(n);
         i_vec_commit = 1'b1;
         next_cycle();
         send_beats(1 + $urandom % (8 - n));
         i_lq_done = 1'b1;
         next_cycle();
         i_vec_commit = 1'b1;
         next_cycle();
         i_lq_commit = 1'b1;
         next_cycle();
      end
      repeat (3) next_cycle();
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Registered outputs against the prediction of the cycle before
   initial begin
      logic       fire, exp_valid, exp_vld;
      logic [2:0] gate;
      vgroup_t    data, exp_data;
      vmask_t     mask, exp_mask;
      fflags_t    flags, exp_flags;
      req_id_t    exp_id;
      {exp_valid, exp_vld} = '0;
      @(negedge i_reset);
      forever begin
         @(negedge i_clk);
         predict(fire, data, mask, flags, gate);
         check_value("o_commit_valid", o_commit_valid, exp_valid);
         if (exp_valid) begin
            check_value("commit payload", {o_commit_data, o_commit_mask, o_commit_fflags},
                        {exp_data, exp_mask, exp_flags});
         end
         check_value("gate outputs", {o_data_req, o_mem_last, o_rd_data_vld_2},
                     {gate[2:1], exp_vld});
         if (exp_vld) begin
            check_value("o_rd_data_resp_id_2", o_rd_data_resp_id_2, exp_id);
         end
         {exp_valid, exp_vld, exp_id}    = {fire, gate[0], i_req_id};
         {exp_data, exp_mask, exp_flags} = {data, mask, flags};
      end
   end

endmodule

`default_nettype wire

// File: vpu_commit_pkg.sv
// Vector commit shared definitions
`default_nettype none

package vpu_commit_pkg;

   localparam int VLEN     = 64;
   localparam int LMUL_MAX = 8;
   localparam int XLEN     = 64;
   localparam int LQ_DEPTH = 8;
   localparam int LQID_W   = 3;
   localparam int REQ_ID_W = 8;
   localparam int FFLAGS_W = 5;
   localparam int BYTEN_W  = VLEN / 8;
   localparam int VL_W     = 7;

   // One register and a full LMUL group
   typedef logic [VLEN-1:0]          vreg_t;
   typedef logic [VLEN*LMUL_MAX-1:0] vgroup_t;
   typedef logic [LMUL_MAX-1:0]      vmask_t;

   typedef logic [FFLAGS_W-1:0] fflags_t;
   typedef logic [XLEN-1:0]     xreg_t;

   // Low LQID_W bits of a request id select the LQ entry
   typedef logic [LQID_W-1:0]   lqid_t;
   typedef logic [REQ_ID_W-1:0] req_id_t;

   typedef logic [BYTEN_W-1:0]  byten_t;
   typedef logic [VL_W-1:0]     vl_t;
   typedef logic [LQ_DEPTH-1:0] lq_flags_t;

endpackage

`default_nettype wire

// File: vpu_commit_top.sv
// Vector commit and load queue glue
`default_nettype none

module vpu_commit_top
   import vpu_commit_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  vl_t     i_csr_vl,

   // Load queue strobes
   input  logic    i_lq_alloc,
   input  lqid_t   i_lq_alloc_id,
   input  logic    i_lq_done,
   input  logic    i_lq_commit,

   // Writeback
   input  logic    i_rf_wr,
   input  xreg_t   i_rf_wrdata,
   input  logic    i_fp_rf_wr,
   input  xreg_t   i_fp_rf_wrdata,
   input  logic    i_vrf_wr,
   input  vreg_t   i_vrf_wrdata,
   input  fflags_t i_vrf_wrexc,
   input  logic    i_vec_commit,

   // Memory requests
   input  logic    i_req_prequal,
   input  logic    i_req_load,
   input  byten_t  i_req_byten,
   input  req_id_t i_req_id,
   input  logic    i_req_last_raw,
   input  logic    i_data_req_rtr,

   output logic    o_commit_valid,
   output vgroup_t o_commit_data,
   output vmask_t  o_commit_mask,
   output fflags_t o_commit_fflags,

   output logic    o_data_req,
   output logic    o_mem_last,
   output logic    o_rd_data_vld_2,
   output req_id_t o_rd_data_resp_id_2
);

   lq_flags_t lq_last;
   logic      head_last;

   commit_beat_if beat_if ();

   lq_last_tracker u_tracker (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_lq_alloc    (i_lq_alloc),
      .i_lq_alloc_id (i_lq_alloc_id),
      .i_lq_done     (i_lq_done),
      .i_lq_commit   (i_lq_commit),
      .o_lq_last     (lq_last),
      .o_head_last   (head_last)
   );

   vrf_group_accum u_accum (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_vrf_wr     (i_vrf_wr),
      .i_vrf_wrdata (i_vrf_wrdata),
      .i_vrf_wrexc  (i_vrf_wrexc),
      .i_csr_vl     (i_csr_vl),
      .beat         (beat_if.accum)
   );

   commit_merge u_merge (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_rf_wr         (i_rf_wr),
      .i_rf_wrdata     (i_rf_wrdata),
      .i_fp_rf_wr      (i_fp_rf_wr),
      .i_fp_rf_wrdata  (i_fp_rf_wrdata),
      .i_vec_commit    (i_vec_commit),
      .i_head_last     (head_last),
      .beat            (beat_if.merge),
      .o_commit_valid  (o_commit_valid),
      .o_commit_data   (o_commit_data),
      .o_commit_mask   (o_commit_mask),
      .o_commit_fflags (o_commit_fflags)
   );

   mem_req_gate u_gate (
      .i_clk               (i_clk),
      .i_reset             (i_reset),
      .i_req_prequal       (i_req_prequal),
      .i_req_load          (i_req_load),
      .i_req_byten         (i_req_byten),
      .i_req_id            (i_req_id),
      .i_req_last_raw      (i_req_last_raw),
      .i_data_req_rtr      (i_data_req_rtr),
      .i_lq_last           (lq_last),
      .o_data_req          (o_data_req),
      .o_mem_last          (o_mem_last),
      .o_rd_data_vld_2     (o_rd_data_vld_2),
      .o_rd_data_resp_id_2 (o_rd_data_resp_id_2)
   );

endmodule

`default_nettype wire

// File: vrf_group_accum.sv
// Vector register group accumulator
`default_nettype none

module vrf_group_accum
   import vpu_commit_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_vrf_wr,
   input  vreg_t             i_vrf_wrdata,
   input  fflags_t           i_vrf_wrexc,
   input  vl_t               i_csr_vl,
   commit_beat_if.accum      beat
);

   logic [$clog2(LMUL_MAX)-1:0] slot_cnt;

   vgroup_t group_q;
   vmask_t  mask_q;
   fflags_t fflags_q;

   vgroup_t group_nxt;
   vmask_t  mask_nxt;
   fflags_t fflags_nxt;

   // Current beat merged into the stored group
   always_comb begin
      group_nxt  = group_q;
      mask_nxt   = mask_q;
      fflags_nxt = fflags_q;
      if (i_vrf_wr) begin
         group_nxt[VLEN*slot_cnt +: VLEN] = i_vrf_wrdata;
         mask_nxt[slot_cnt]               = |i_csr_vl;
         fflags_nxt                       = fflags_q | i_vrf_wrexc;
      end
   end

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         slot_cnt <= '0;
         group_q  <= '0;
         mask_q   <= '0;
         fflags_q <= '0;
      end else begin
         if (beat.commit_fire) begin
            // Next instruction starts at slot zero
            slot_cnt <= '0;
            group_q  <= '0;
            mask_q   <= '0;
            fflags_q <= '0;
         end else if (i_vrf_wr) begin
            slot_cnt <= slot_cnt + 1'b1;
            group_q  <= group_nxt;
            mask_q   <= mask_nxt;
            fflags_q <= fflags_nxt;
         end
      end
   end

   assign beat.group_nxt  = group_nxt;
   assign beat.mask_nxt   = mask_nxt;
   assign beat.fflags_nxt = fflags_nxt;

endmodule

`default_nettype wire
